// ==== design/mem_pkg.sv ====
package mem_pkg;

    // control word fields
    localparam int CTRL_TYPE_LSB = 0;
    localparam int CTRL_TYPE_MSB = 3;
    localparam int CTRL_SUB_LSB  = 7;
    localparam int CTRL_SUB_MSB  = 11;

    // operation classes
    localparam logic [3:0] TYPE_MEM    = 4'd5;
    localparam logic [3:0] TYPE_ATOMIC = 4'd6;

    // subtypes of TYPE_MEM
    localparam logic [4:0] SUB_LD_B  = 5'd0;
    localparam logic [4:0] SUB_LD_H  = 5'd1;
    localparam logic [4:0] SUB_LD_W  = 5'd2;
    localparam logic [4:0] SUB_ST_B  = 5'd3;
    localparam logic [4:0] SUB_ST_H  = 5'd4;
    localparam logic [4:0] SUB_ST_W  = 5'd5;
    localparam logic [4:0] SUB_LD_BU = 5'd6;
    localparam logic [4:0] SUB_LD_HU = 5'd7;

    // subtypes of TYPE_ATOMIC
    localparam logic [4:0] SUB_LL_W = 5'd0;
    localparam logic [4:0] SUB_SC_W = 5'd1;

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;    // addr[9:2], upper bits alias

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;    // replicated into lanes
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        mem_size_e   size;
        logic        sign;
        logic [1:0]  lane;
        logic [31:0] addr;
        logic        ale;
    } load_info_t;

    typedef struct packed {
        logic        ale;
        logic [31:0] data;    // fault address when ale
    } wb_t;

endpackage

// ==== design/pipe_reg.sv ====
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // payload held when idle
    always_ff @(posedge clk)
    begin
        if (in_valid)
            out_data <= in_data;
    end

    a_payload_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_data)
    ) else $error("pipe_reg: unknown payload while valid");

endmodule

// ==== design/dcache_req_decode.sv ====
`timescale 1ns/10ps

module dcache_req_decode (
    input  logic [31:0]         rj_val,
    input  logic [31:0]         imm,
    input  logic [31:0]         ctrl,
    input  logic [31:0]         rd_val,
    output mem_pkg::mem_req_t   req,
    output mem_pkg::load_info_t linfo,
    output logic                load_en
);
    import mem_pkg::*;

    logic [31:0] addr;
    logic [3:0]  ctrl_type;
    logic [4:0]  ctrl_sub;
    logic        op_ok;
    logic        op_wr;
    logic        op_sign;
    mem_size_e   op_size;
    logic        misaligned;
    logic [3:0]  strb;
    logic [31:0] lane_data;

    assign addr      = rj_val + imm;
    assign ctrl_type = ctrl[CTRL_TYPE_MSB:CTRL_TYPE_LSB];
    assign ctrl_sub  = ctrl[CTRL_SUB_MSB:CTRL_SUB_LSB];

    // class/subtype to operation
    always_comb
    begin
        op_ok   = 1'b0;
        op_wr   = 1'b0;
        op_sign = 1'b0;
        op_size = MEM_WORD;
        if (ctrl_type == TYPE_MEM)
        begin
            case (ctrl_sub)
                SUB_LD_B:
                begin
                    op_ok   = 1'b1;
                    op_sign = 1'b1;
                    op_size = MEM_BYTE;
                end
                SUB_LD_H:
                begin
                    op_ok   = 1'b1;
                    op_sign = 1'b1;
                    op_size = MEM_HALF;
                end
                SUB_LD_W: op_ok = 1'b1;
                SUB_ST_B:
                begin
                    op_ok   = 1'b1;
                    op_wr   = 1'b1;
                    op_size = MEM_BYTE;
                end
                SUB_ST_H:
                begin
                    op_ok   = 1'b1;
                    op_wr   = 1'b1;
                    op_size = MEM_HALF;
                end
                SUB_ST_W:
                begin
                    op_ok = 1'b1;
                    op_wr = 1'b1;
                end
                SUB_LD_BU:
                begin
                    op_ok   = 1'b1;
                    op_size = MEM_BYTE;
                end
                SUB_LD_HU:
                begin
                    op_ok   = 1'b1;
                    op_size = MEM_HALF;
                end
                default: op_ok = 1'b0;    // ibar and the rest
            endcase
        end
        else if (ctrl_type == TYPE_ATOMIC)
        begin
            // no reservation, plain word access
            op_ok = (ctrl_sub == SUB_LL_W) || (ctrl_sub == SUB_SC_W);
            op_wr = (ctrl_sub == SUB_SC_W);
        end
    end

    // lanes, strobes, alignment
    always_comb
    begin
        case (op_size)
            MEM_BYTE:
            begin
                misaligned = 1'b0;
                strb       = 4'b0001 << addr[1:0];
                lane_data  = {4{rd_val[7:0]}};
            end
            MEM_HALF:
            begin
                misaligned = addr[0];
                strb       = addr[1] ? 4'b1100 : 4'b0011;
                lane_data  = {2{rd_val[15:0]}};
            end
            default:
            begin
                misaligned = |addr[1:0];
                strb       = 4'b1111;
                lane_data  = rd_val;
            end
        endcase
    end

    always_comb
    begin
        req = '0;
        if (op_ok && !misaligned)
        begin
            req.valid = 1'b1;
            req.write = op_wr;
            req.addr  = addr;
            req.wdata = op_wr ? lane_data : 32'd0;
            req.wstrb = strb;
        end
        linfo.size = op_size;
        linfo.sign = op_sign;
        linfo.lane = addr[1:0];
        linfo.addr = addr;
        linfo.ale  = op_ok & misaligned;
        load_en    = op_ok & (~op_wr | misaligned);    // stores only report ale
    end

endmodule

// ==== design/data_sram.sv ====
`timescale 1ns/10ps

module data_sram (
    input  logic              clk,
    input  mem_pkg::mem_req_t req,
    output logic [31:0]       rdata
);
    import mem_pkg::*;

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;

    assign idx = req.addr[RAM_AW+1:2];    // word index

    initial
    begin
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = 32'd0;
    end

    // byte lane writes
    always @(posedge clk)
    begin
        if (req.valid && req.write)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (req.wstrb[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    // one cycle read, earlier writes already in array
    always_ff @(posedge clk)
    begin
        if (req.valid && !req.write)
            rdata <= mem[idx];
    end

    a_write_strobe: assert property (
        @(posedge clk)
        (req.valid && req.write) |-> (req.wstrb != 4'd0)
    ) else $error("data_sram: write with empty strobe");

    // wstrb is ignored on reads, only the returned word matters
    a_read_known: assert property (
        @(posedge clk)
        (req.valid && !req.write) |=> !$isunknown(rdata)
    ) else $error("data_sram: unknown read data");

endmodule

// ==== design/load_align.sv ====
`timescale 1ns/10ps

module load_align (
    input  mem_pkg::load_info_t linfo,
    input  logic [31:0]         rdata,
    output mem_pkg::wb_t        wb
);
    import mem_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] value;

    // little endian lane pick
    always_comb
    begin
        case (linfo.lane)
            2'd0:    sel_byte = rdata[7:0];
            2'd1:    sel_byte = rdata[15:8];
            2'd2:    sel_byte = rdata[23:16];
            default: sel_byte = rdata[31:24];
        endcase
        sel_half = linfo.lane[1] ? rdata[31:16] : rdata[15:0];
    end

    always_comb
    begin
        case (linfo.size)
            MEM_BYTE: value = {{24{linfo.sign & sel_byte[7]}}, sel_byte};
            MEM_HALF: value = {{16{linfo.sign & sel_half[15]}}, sel_half};
            default:  value = rdata;
        endcase
    end

    always_comb
    begin
        wb.ale  = linfo.ale;
        wb.data = linfo.ale ? linfo.addr : value;    // badv on ale
    end

endmodule

// ==== design/mem_stage_top.sv ====
`timescale 1ns/10ps

module mem_stage_top (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  rj_val,
    input  logic [31:0]  imm,
    input  logic [31:0]  ctrl,
    input  logic [31:0]  rd_val,
    output logic         wb_valid,
    output mem_pkg::wb_t wb
);
    import mem_pkg::*;

    mem_req_t    req;
    load_info_t  linfo_d;
    load_info_t  linfo_q;
    logic        load_en;
    logic        load_vld;
    logic [31:0] rdata;
    wb_t         wb_d;

    dcache_req_decode dcache_req_decode_i (
        .rj_val  (rj_val),
        .imm     (imm),
        .ctrl    (ctrl),
        .rd_val  (rd_val),
        .req     (req),
        .linfo   (linfo_d),
        .load_en (load_en)
    );

    data_sram data_sram_i (
        .clk   (clk),
        .req   (req),
        .rdata (rdata)
    );

    // same edge as the ram read
    pipe_reg #(
        .payload_t (load_info_t)
    ) load_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (load_en),
        .in_data   (linfo_d),
        .out_valid (load_vld),
        .out_data  (linfo_q)
    );

    load_align load_align_i (
        .linfo (linfo_q),
        .rdata (rdata),
        .wb    (wb_d)
    );

    pipe_reg #(
        .payload_t (wb_t)
    ) wb_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (load_vld),
        .in_data   (wb_d),
        .out_valid (wb_valid),
        .out_data  (wb)
    );

endmodule

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/10ps

module mem_stage_tb;
    import mem_pkg::*;

    localparam int NUM_OPS     = 600;
    localparam int DRAIN_LIMIT = 8;
    localparam int CLK_HALF    = 20;
    localparam int MODEL_BYTES = 1024;

    typedef struct packed {
        logic [31:0] due;     // negedge count where wb must show
        logic        ale;
        logic [31:0] data;
    } exp_wb_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] rj_val;
    logic [31:0] imm;
    logic [31:0] ctrl;
    logic [31:0] rd_val;
    logic        wb_valid;
    wb_t         wb;

    logic [7:0]  model_mem [MODEL_BYTES];
    exp_wb_t     pending [$];
    logic [31:0] rng_state;
    logic [31:0] last_rj;
    logic [31:0] last_imm;
    int          cycle_cnt;
    int          drain_cnt;
    int          errors;
    int          checks;
    int          loads_seen;
    int          stores_seen;
    int          ale_seen;

    mem_stage_top mem_stage_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rj_val   (rj_val),
        .imm      (imm),
        .ctrl     (ctrl),
        .rd_val   (rd_val),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // upper half of the lcg state
    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {16'd0, rng_state[31:16]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0d ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        exp_wb_t head;
        if (pending.size() != 0 && pending[0].due == cycle_cnt)
        begin
            head = pending.pop_front();
            if (wb_valid !== 1'b1)
            begin
                errors++;
                $display("ERROR at %0d ns: expected writeback (data %08h) did not arrive",
                         $time, head.data);
            end
            else
            begin
                check_value("wb.ale", {31'd0, wb.ale}, {31'd0, head.ale});
                check_value("wb.data", wb.data, head.data);
            end
        end
        else
            check_value("wb_valid", {31'd0, wb_valid}, 32'd0);    // nothing due
    endtask

    task automatic issue_op();
        logic [31:0] sel;
        logic [31:0] rnd;
        logic [3:0]  cls;
        logic [4:0]  sub;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] ctrl_v;
        logic [31:0] rd_v;
        logic        supported;
        logic        is_store;
        logic        sign;
        int          nbytes;
        int          a;
        exp_wb_t     e;
        sel = next_rand() % 12;
        rnd = next_rand();
        sub = rnd[4:0];
        if (sel < 8)
        begin
            cls = TYPE_MEM;
            sub = sel[4:0];
        end
        else if (sel == 8)
        begin
            cls = TYPE_ATOMIC;
            sub = SUB_LL_W;
        end
        else if (sel == 9)
        begin
            cls = TYPE_ATOMIC;
            sub = SUB_SC_W;
        end
        else if (sel == 10)
        begin
            cls = TYPE_MEM;
            sub = 5'd8;    // ibar
        end
        else
            cls = rnd[5] ? TYPE_ATOMIC : 4'd9;    // any atomic subtype or unknown class
        if (next_rand() % 4 != 0)
        begin
            last_rj = next_rand() % 2048;
            if (next_rand() % 4 != 0)
                last_rj[1:0] = 2'b00;
            last_imm = (next_rand() % 16) * 32'd4 - 32'd32;
        end
        ctrl_v = (next_rand() << 16) | next_rand();
        ctrl_v[CTRL_TYPE_MSB:CTRL_TYPE_LSB] = cls;
        ctrl_v[CTRL_SUB_MSB:CTRL_SUB_LSB]   = sub;
        rd_v = (next_rand() << 16) | next_rand();
        rj_val = last_rj;
        imm    = last_imm;
        ctrl   = ctrl_v;
        rd_val = rd_v;

        supported = 1'b0;
        is_store  = 1'b0;
        sign      = 1'b0;
        nbytes    = 4;
        if (cls == TYPE_MEM && sub <= 5'd7)
        begin
            supported = 1'b1;
            if (sub == SUB_LD_B || sub == SUB_ST_B || sub == SUB_LD_BU)
                nbytes = 1;
            else if (sub == SUB_LD_H || sub == SUB_ST_H || sub == SUB_LD_HU)
                nbytes = 2;
            is_store = (sub == SUB_ST_B) || (sub == SUB_ST_H) || (sub == SUB_ST_W);
            sign     = (sub == SUB_LD_B) || (sub == SUB_LD_H);
        end
        else if (cls == TYPE_ATOMIC && sub <= 5'd1)
        begin
            supported = 1'b1;
            is_store  = (sub == SUB_SC_W);
        end
        if (!supported)
            return;

        addr = last_rj + last_imm;
        a    = int'(addr[9:0]);    // aliases modulo 1 KiB
        e.due = cycle_cnt + 2;
        if ((addr[1:0] & 2'(nbytes - 1)) != 2'd0)
        begin
            e.ale  = 1'b1;
            e.data = addr;
            pending.push_back(e);
            ale_seen++;
        end
        else if (is_store)
        begin
            for (int i = 0; i < nbytes; i++)
                model_mem[(a + i) % MODEL_BYTES] = rd_v[8*i +: 8];
            stores_seen++;
        end
        else
        begin
            value = 32'd0;
            for (int i = 0; i < nbytes; i++)
                value[8*i +: 8] = model_mem[(a + i) % MODEL_BYTES];
            if (sign && nbytes < 4 && value[8*nbytes-1])
                value = value | (32'hffff_ffff << (8 * nbytes));
            e.ale  = 1'b0;
            e.data = value;
            pending.push_back(e);
            loads_seen++;
        end
    endtask

    initial
    begin
        rng_state   = 32'd78149;
        rst_n       = 1'b0;
        rj_val      = 32'd0;
        imm         = 32'd0;
        ctrl        = 32'd0;
        rd_val      = 32'd0;
        last_rj     = 32'd0;
        last_imm    = 32'd0;
        cycle_cnt   = 0;
        drain_cnt   = 0;
        errors      = 0;
        checks      = 0;
        loads_seen  = 0;
        stores_seen = 0;
        ale_seen    = 0;
        for (int i = 0; i < MODEL_BYTES; i++)
            model_mem[i] = 8'h00;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("wb_valid after reset", {31'd0, wb_valid}, 32'd0);

        for (int n = 0; n < NUM_OPS; n++)
        begin
            issue_op();
            @(negedge clk);
            cycle_cnt++;
            check_outputs();
        end

        ctrl = 32'd0;    // class 0 is idle
        while (pending.size() != 0 && drain_cnt < DRAIN_LIMIT)
        begin
            @(negedge clk);
            cycle_cnt++;
            drain_cnt++;
            check_outputs();
        end
        if (pending.size() != 0)
        begin
            errors++;
            $display("Timeout: %0d expected writebacks never arrived", pending.size());
        end
        repeat (2)
        begin
            @(negedge clk);
            cycle_cnt++;
            check_outputs();
        end

        $display("Checks: %0d, loads: %0d, stores: %0d, address errors: %0d, errors: %0d",
                 checks, loads_seen, stores_seen, ale_seen, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
design/mem_pkg.sv
design/pipe_reg.sv
design/dcache_req_decode.sv
design/data_sram.sv
design/load_align.sv
design/mem_stage_top.sv
test/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - design/mem_pkg.sv
  - design/pipe_reg.sv
  - design/dcache_req_decode.sv
  - design/data_sram.sv
  - design/load_align.sv
  - design/mem_stage_top.sv
  - target: test
    files:
      - test/mem_stage_tb.sv
